//--- sdcard_pkg.sv
// ======================================
// Shared card states, command codes and
// configuration for the SD command model
// ======================================
`default_nettype none

package sdcard_pkg;

    typedef enum logic [3:0] {
        SDSTATE_IDLE  = 4'd0,
        SDSTATE_READY = 4'd1,
        SDSTATE_IDENT = 4'd2,
        SDSTATE_STBY  = 4'd3,
        SDSTATE_INA   = 4'd4
    } sdstate_t;

    // Card configuration
    localparam int SDCARD_POWERUP_CYCLES = 400;
    localparam int SDCARD_RESP_DELAY = 4;
    localparam int SDCARD_GAP_CYCLES = 2;
    localparam logic SDCARD_HCS = 1'b1;
    localparam logic [3:0] SDCARD_VHS = 4'h1;
    localparam logic SDCARD_PCIE_1_2V = 1'b0;
    localparam logic SDCARD_PCIE_AVAIL = 1'b0;
    localparam logic [23:0] SDCARD_VDD_WINDOW = 24'hff8000;
    localparam logic [15:0] SDCARD_RCA = 16'h1234;
    localparam logic [31:0] SDCARD_CID_WORD = 32'h5a3c_9e01;

    // Frame layout, start bit is position 0
    localparam int SDCARD_FRAME_LEN = 48;
    localparam int SDCARD_CRC_POS = 40;

    // Command indices
    localparam logic [5:0] CMD_GO_IDLE = 6'd0;
    localparam logic [5:0] CMD_ALL_SEND_CID = 6'd2;
    localparam logic [5:0] CMD_SEND_RCA = 6'd3;
    localparam logic [5:0] CMD_IF_COND = 6'd8;
    localparam logic [5:0] CMD_VOLT_SWITCH = 6'd11;
    localparam logic [5:0] CMD_APP = 6'd55;
    localparam logic [5:0] ACMD_OP_COND = 6'd41;
    localparam logic [5:0] CMD_READ_OCR = 6'd58;

    // One serial step of CRC7, polynomial x^7 + x^3 + 1
    function automatic logic [6:0] crc7_next(input logic [6:0] crc, input logic din);
        logic fb;
        fb = crc[6] ^ din;
        return {crc[5:3], crc[2] ^ fb, crc[1:0], fb};
    endfunction

endpackage

`default_nettype wire

//--- sdcard_cmd_rx.sv
// ======================================
// Receives host command frames from CMD
// and hands good ones to the controller
// ======================================
`timescale 1ns/1ps
`default_nettype none

module sdcard_cmd_rx
    import sdcard_pkg::*;
(
    input  wire logic        i_clk,
    input  wire logic        i_nrst,
    input  wire logic        i_cmd,
    output logic             o_req_valid,
    output logic [5:0]       o_req_cmd,
    output logic [31:0]      o_req_arg,
    input  wire logic        i_req_ready
);

    localparam logic [5:0] LAST_BIT = 6'(SDCARD_FRAME_LEN - 1);
    localparam logic [5:0] CRC_BIT = 6'(SDCARD_CRC_POS);

    logic        rx_busy;
    logic [5:0]  bit_cnt;
    logic [6:0]  crc;
    logic [45:0] shreg;
    logic        frame_ok;
    logic        frame_end;

    // Bits 1..46 sit in shreg when the end bit arrives
    assign frame_end = rx_busy && (bit_cnt == LAST_BIT);
    assign frame_ok = shreg[45] && i_cmd && (shreg[6:0] == crc);

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            rx_busy <= 1'b0;
            bit_cnt <= '0;
            crc <= '0;
            o_req_valid <= 1'b0;
        end else begin
            if (o_req_valid && i_req_ready) begin
                o_req_valid <= 1'b0;
            end
            if (!rx_busy) begin
                // Start bits are ignored while a request still waits
                if (!o_req_valid && !i_cmd) begin
                    rx_busy <= 1'b1;
                    bit_cnt <= 6'd1;
                    // CRC over a single 0 start bit is still zero
                    crc <= '0;
                end
            end else begin
                bit_cnt <= bit_cnt + 6'd1;
                if (bit_cnt < CRC_BIT) begin
                    crc <= crc7_next(crc, i_cmd);
                end
                if (frame_end) begin
                    rx_busy <= 1'b0;
                    o_req_valid <= frame_ok;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (rx_busy) begin
            shreg <= {shreg[44:0], i_cmd};
        end
    end

    // Request fields, loaded only for a frame that passed all checks
    always_ff @(posedge i_clk) begin
        if (frame_end && frame_ok) begin
            o_req_cmd <= shreg[44:39];
            o_req_arg <= shreg[38:7];
        end
    end

endmodule

`default_nettype wire

//--- sdcard_ctrl.sv
// ======================================
// Card identification FSM, decodes each
// command and prepares its response
// ======================================
`timescale 1ns/1ps
`default_nettype none

module sdcard_ctrl
    import sdcard_pkg::*;
(
    input  wire logic        i_clk,
    input  wire logic        i_nrst,
    input  wire logic        i_spi_mode,
    input  wire logic        i_req_valid,
    input  wire logic [5:0]  i_req_cmd,
    input  wire logic [31:0] i_req_arg,
    output logic             o_req_ready,
    output logic             o_resp_valid,
    output logic [5:0]       o_resp_index,
    output logic [31:0]      o_resp_data,
    output logic             o_resp_no_crc,
    input  wire logic        i_resp_ready,
    output logic             o_idle_state,
    output logic             o_illegal_cmd
);

    localparam int PU_W = $clog2(SDCARD_POWERUP_CYCLES + 1);
    localparam int DLY_W = $clog2(SDCARD_RESP_DELAY + 1);
    localparam logic [PU_W-1:0] PU_LAST = PU_W'(SDCARD_POWERUP_CYCLES - 1);

    sdstate_t         state;
    sdstate_t         dec_state;
    logic [PU_W-1:0]  powerup_cnt;
    logic             powerup_done;
    logic [DLY_W-1:0] delay_cnt;
    logic             pend;
    logic             resp_en;
    logic             resp_illegal;
    logic             accept;
    logic             dec_resp;
    logic [31:0]      dec_data;
    logic             dec_illegal;
    logic             dec_no_crc;
    logic [23:0]      ocr_match;

    assign accept = i_req_valid && !pend;
    assign o_req_ready = !pend;
    assign o_idle_state = (state == SDSTATE_IDLE);
    assign o_illegal_cmd = o_resp_valid && resp_illegal;
    assign ocr_match = i_req_arg[23:0] & SDCARD_VDD_WINDOW;

    // Command decode against the current card state
    always_comb begin
        dec_state = state;
        dec_resp = 1'b1;
        dec_data = '0;
        dec_illegal = 1'b0;
        dec_no_crc = 1'b0;
        if ((i_req_cmd == CMD_GO_IDLE) && (state != SDSTATE_INA)) begin
            dec_state = SDSTATE_IDLE;
        end else begin
            case (state)
                SDSTATE_IDLE: begin
                    case (i_req_cmd)
                        CMD_IF_COND: begin
                            dec_data[13] = i_req_arg[13] & SDCARD_PCIE_1_2V;
                            dec_data[12] = i_req_arg[12] & SDCARD_PCIE_AVAIL;
                            dec_data[11:8] = i_req_arg[11:8] & SDCARD_VHS;
                            dec_data[7:0] = i_req_arg[7:0];
                        end
                        CMD_APP: begin
                            dec_data = '0;
                        end
                        ACMD_OP_COND: begin
                            dec_no_crc = 1'b1;
                            dec_data[31] = powerup_done;
                            dec_data[30] = i_req_arg[30];
                            dec_data[23:0] = ocr_match;
                            if (ocr_match == '0) begin
                                // No common voltage, card drops out
                                dec_state = SDSTATE_INA;
                            end else if (powerup_done && !i_spi_mode) begin
                                dec_state = SDSTATE_READY;
                            end
                        end
                        CMD_READ_OCR: begin
                            if (i_spi_mode) begin
                                dec_data[30] = SDCARD_HCS;
                                dec_data[23:0] = SDCARD_VDD_WINDOW;
                            end else begin
                                dec_data = '1;
                                dec_illegal = 1'b1;
                            end
                        end
                        default: begin
                            dec_data = '1;
                            dec_illegal = 1'b1;
                        end
                    endcase
                end
                SDSTATE_READY: begin
                    if (i_req_cmd == CMD_ALL_SEND_CID) begin
                        dec_data = SDCARD_CID_WORD;
                        dec_state = SDSTATE_IDENT;
                    end else if (i_req_cmd != CMD_VOLT_SWITCH) begin
                        dec_data = '1;
                        dec_illegal = 1'b1;
                    end
                end
                SDSTATE_IDENT: begin
                    if (i_req_cmd == CMD_SEND_RCA) begin
                        dec_data = {SDCARD_RCA, 16'h0000};
                        dec_state = SDSTATE_STBY;
                    end else begin
                        dec_data = '1;
                        dec_illegal = 1'b1;
                    end
                end
                // STBY and INA stay silent
                default: begin
                    dec_resp = 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state <= SDSTATE_IDLE;
            powerup_cnt <= '0;
            powerup_done <= 1'b0;
            delay_cnt <= '0;
            pend <= 1'b0;
            resp_en <= 1'b0;
            o_resp_valid <= 1'b0;
        end else begin
            // Emulated power-up time for the ACMD41 busy bit
            if (!powerup_done) begin
                if (powerup_cnt == PU_LAST) begin
                    powerup_done <= 1'b1;
                end else begin
                    powerup_cnt <= powerup_cnt + 1'b1;
                end
            end
            if (accept) begin
                state <= dec_state;
                pend <= 1'b1;
                resp_en <= dec_resp;
                delay_cnt <= DLY_W'(SDCARD_RESP_DELAY);
            end else if (pend && !o_resp_valid) begin
                if (delay_cnt != '0) begin
                    delay_cnt <= delay_cnt - 1'b1;
                end else if (resp_en) begin
                    o_resp_valid <= 1'b1;
                end else begin
                    pend <= 1'b0;
                end
            end
            if (o_resp_valid && i_resp_ready) begin
                o_resp_valid <= 1'b0;
                pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            o_resp_index <= i_req_cmd;
            o_resp_data <= dec_data;
            o_resp_no_crc <= dec_no_crc;
            resp_illegal <= dec_illegal;
        end
    end

endmodule

`default_nettype wire

//--- sdcard_resp_tx.sv
// ======================================
// Sends response frames with CRC7 on CMD
// after a short idle-high gap
// ======================================
`timescale 1ns/1ps
`default_nettype none

module sdcard_resp_tx
    import sdcard_pkg::*;
(
    input  wire logic        i_clk,
    input  wire logic        i_nrst,
    input  wire logic        i_resp_valid,
    input  wire logic [5:0]  i_resp_index,
    input  wire logic [31:0] i_resp_data,
    input  wire logic        i_resp_no_crc,
    output logic             o_resp_ready,
    output logic             o_cmd,
    output logic             o_cmd_oe
);

    localparam int GAP_W = $clog2(SDCARD_GAP_CYCLES + 1);
    localparam logic [5:0] LAST_BIT = 6'(SDCARD_FRAME_LEN - 1);
    localparam logic [5:0] CRC_BIT = 6'(SDCARD_CRC_POS);

    logic             tx_busy;
    logic [GAP_W-1:0] gap_cnt;
    logic [5:0]       bit_cnt;
    logic [39:0]      shreg;
    logic [6:0]       crc;
    logic             no_crc;
    logic             accept;
    logic             in_frame;
    logic             frame_bit;

    assign accept = i_resp_valid && o_resp_ready;
    assign o_resp_ready = !tx_busy;
    assign in_frame = tx_busy && (gap_cnt == '0);

    // Line turns around as soon as a response is offered
    assign o_cmd_oe = tx_busy || i_resp_valid;

    always_comb begin
        if (bit_cnt < CRC_BIT) begin
            frame_bit = shreg[39];
        end else if (bit_cnt < LAST_BIT) begin
            frame_bit = no_crc || crc[6];
        end else begin
            frame_bit = 1'b1;
        end
    end

    assign o_cmd = in_frame ? frame_bit : 1'b1;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            tx_busy <= 1'b0;
            gap_cnt <= '0;
            bit_cnt <= '0;
        end else if (accept) begin
            tx_busy <= 1'b1;
            gap_cnt <= GAP_W'(SDCARD_GAP_CYCLES);
            bit_cnt <= '0;
        end else if (tx_busy) begin
            if (gap_cnt != '0) begin
                gap_cnt <= gap_cnt - 1'b1;
            end else begin
                bit_cnt <= bit_cnt + 6'd1;
                if (bit_cnt == LAST_BIT) begin
                    tx_busy <= 1'b0;
                end
            end
        end
    end

    // Frame body and CRC shifter
    always_ff @(posedge i_clk) begin
        if (accept) begin
            // R3 replaces the index with all ones
            shreg <= {2'b00, (i_resp_no_crc ? 6'h3f : i_resp_index), i_resp_data};
            crc <= '0;
            no_crc <= i_resp_no_crc;
        end else if (in_frame) begin
            if (bit_cnt < CRC_BIT) begin
                shreg <= {shreg[38:0], 1'b0};
                crc <= crc7_next(crc, shreg[39]);
            end else begin
                crc <= {crc[5:0], 1'b1};
            end
        end
    end

endmodule

`default_nettype wire

//--- sdcard_model.sv
// ======================================
// Card-side SD command model, wire the
// host CMD line to i_cmd and o_cmd
// ======================================
`timescale 1ns/1ps
`default_nettype none

module sdcard_model (
    input  wire logic i_clk,
    input  wire logic i_nrst,
    input  wire logic i_spi_mode,
    input  wire logic i_cmd,
    output logic      o_cmd,
    output logic      o_cmd_oe,
    output logic      o_idle_state,
    output logic      o_illegal_cmd
);

    logic        req_valid;
    logic [5:0]  req_cmd;
    logic [31:0] req_arg;
    logic        req_ready;
    logic        resp_valid;
    logic [5:0]  resp_index;
    logic [31:0] resp_data;
    logic        resp_no_crc;
    logic        resp_ready;

    sdcard_cmd_rx u_cmd_rx (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_cmd       (i_cmd),
        .o_req_valid (req_valid),
        .o_req_cmd   (req_cmd),
        .o_req_arg   (req_arg),
        .i_req_ready (req_ready)
    );

    sdcard_ctrl u_ctrl (
        .i_clk         (i_clk),
        .i_nrst        (i_nrst),
        .i_spi_mode    (i_spi_mode),
        .i_req_valid   (req_valid),
        .i_req_cmd     (req_cmd),
        .i_req_arg     (req_arg),
        .o_req_ready   (req_ready),
        .o_resp_valid  (resp_valid),
        .o_resp_index  (resp_index),
        .o_resp_data   (resp_data),
        .o_resp_no_crc (resp_no_crc),
        .i_resp_ready  (resp_ready),
        .o_idle_state  (o_idle_state),
        .o_illegal_cmd (o_illegal_cmd)
    );

    sdcard_resp_tx u_resp_tx (
        .i_clk         (i_clk),
        .i_nrst        (i_nrst),
        .i_resp_valid  (resp_valid),
        .i_resp_index  (resp_index),
        .i_resp_data   (resp_data),
        .i_resp_no_crc (resp_no_crc),
        .o_resp_ready  (resp_ready),
        .o_cmd         (o_cmd),
        .o_cmd_oe      (o_cmd_oe)
    );

endmodule

`default_nettype wire

//--- sdcard_model_asserts.sv
// ======================================
// Handshake and CMD line checks bound
// into the SD command model top level
// ======================================
`timescale 1ns/1ps
`default_nettype none

module sdcard_model_asserts (
    input wire logic        i_clk,
    input wire logic        i_nrst,
    input wire logic        i_req_valid,
    input wire logic        i_req_ready,
    input wire logic [5:0]  i_req_cmd,
    input wire logic [31:0] i_req_arg,
    input wire logic        i_resp_valid,
    input wire logic        i_resp_ready,
    input wire logic [5:0]  i_resp_index,
    input wire logic [31:0] i_resp_data,
    input wire logic        i_resp_no_crc,
    input wire logic        i_illegal_cmd,
    input wire logic        i_cmd_out,
    input wire logic        i_cmd_oe
);

    int assert_errs = 0;

    // Request held until the controller takes it
    a_req_stable: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (i_req_valid && !i_req_ready) |=>
            (i_req_valid && $stable(i_req_cmd) && $stable(i_req_arg)))
    else begin
        assert_errs++;
        $error("request changed before it was accepted");
    end

    a_resp_stable: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (i_resp_valid && !i_resp_ready) |=>
            (i_resp_valid && $stable(i_resp_index) && $stable(i_resp_data)
             && $stable(i_resp_no_crc)))
    else begin
        assert_errs++;
        $error("response changed before it was accepted");
    end

    // Released line idles high
    a_line_idle: assert property (@(posedge i_clk) disable iff (!i_nrst)
        !i_cmd_oe |-> i_cmd_out)
    else begin
        assert_errs++;
        $error("CMD line low while not driven");
    end

    // Illegal flag only with a pending all-ones response
    a_illegal_valid: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_illegal_cmd |-> (i_resp_valid && (i_resp_data == '1)))
    else begin
        assert_errs++;
        $error("illegal flag high without a pending all-ones response");
    end

endmodule

bind sdcard_model sdcard_model_asserts u_asserts (
    .i_clk         (i_clk),
    .i_nrst        (i_nrst),
    .i_req_valid   (req_valid),
    .i_req_ready   (req_ready),
    .i_req_cmd     (req_cmd),
    .i_req_arg     (req_arg),
    .i_resp_valid  (resp_valid),
    .i_resp_ready  (resp_ready),
    .i_resp_index  (resp_index),
    .i_resp_data   (resp_data),
    .i_resp_no_crc (resp_no_crc),
    .i_illegal_cmd (o_illegal_cmd),
    .i_cmd_out     (o_cmd),
    .i_cmd_oe      (o_cmd_oe)
);

`default_nettype wire

//--- tb_sdcard_model.sv
// ======================================
// Testbench that replays the golden command
// list and decodes each card response
// ======================================
`timescale 1ns/1ps
`default_nettype none

module tb_sdcard_model
    import sdcard_pkg::*;
;

    localparam int RESP_TIMEOUT = 200;

    logic i_clk;
    logic i_nrst;
    logic i_spi_mode;
    logic i_cmd;
    logic o_cmd;
    logic o_cmd_oe;
    logic o_idle_state;
    logic o_illegal_cmd;

    int cycle;
    int errors;
    int checks;
    int n_cmds;
    int n_failed;

    sdcard_model DUT (
        .i_clk         (i_clk),
        .i_nrst        (i_nrst),
        .i_spi_mode    (i_spi_mode),
        .i_cmd         (i_cmd),
        .o_cmd         (o_cmd),
        .o_cmd_oe      (o_cmd_oe),
        .o_idle_state  (o_idle_state),
        .o_illegal_cmd (o_illegal_cmd)
    );

    always #5 i_clk = ~i_clk;

    // Cycles since reset release
    always @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            cycle <= 0;
        end else begin
            cycle <= cycle + 1;
        end
    end

    // CRC7 of 40 frame bits MSB first with x^7 + x^3 + 1
    function automatic logic [6:0] frame_crc7(input logic [39:0] bits);
        logic [6:0] crc;
        logic       fb;
        int         i;
        crc = '0;
        for (i = 39; i >= 0; i--) begin
            fb = crc[6] ^ bits[i];
            crc = {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
        end
        return crc;
    endfunction

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0d ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("At %0d ns: %s", $time, msg);
    endtask

    // Outputs right after reset release
    task automatic check_reset_outputs();
        int err_before;
        err_before = errors;
        compare_value("line enable after reset", o_cmd_oe, 1'b0);
        compare_value("line level after reset", o_cmd, 1'b1);
        compare_value("idle state after reset", o_idle_state, 1'b1);
        compare_value("illegal flag after reset", o_illegal_cmd, 1'b0);
        $display("reset outputs: %s", (errors == err_before) ? "ok" : "mismatch");
    endtask

    task automatic send_frame(input logic [5:0] idx, input logic [31:0] arg,
                              input logic corrupt);
        logic [47:0] frame;
        logic [6:0]  crc;
        int          i;
        crc = frame_crc7({2'b01, idx, arg});
        if (corrupt) begin
            crc = crc ^ 7'h01;
        end
        frame = {2'b01, idx, arg, crc, 1'b1};
        for (i = 47; i >= 0; i--) begin
            @(negedge i_clk);
            i_cmd = frame[i];
        end
    endtask

    // Bounded hunt for a start bit before reading the rest of the frame
    task automatic receive_frame(output logic got_resp, output logic illegal,
                                 output logic [47:0] frame);
        logic oe_seen;
        int   n;
        int   i;
        got_resp = 1'b0;
        illegal = 1'b0;
        oe_seen = 1'b0;
        frame = '1;
        n = 0;
        while (!got_resp && n < RESP_TIMEOUT) begin
            @(negedge i_clk);
            if (o_cmd_oe && !oe_seen) begin
                oe_seen = 1'b1;
                illegal = o_illegal_cmd;
            end
            if (o_cmd_oe && !o_cmd) begin
                got_resp = 1'b1;
            end
            n++;
        end
        if (got_resp) begin
            frame[47] = 1'b0;
            for (i = 46; i >= 0; i--) begin
                @(negedge i_clk);
                frame[i] = o_cmd;
            end
        end
    endtask

    task automatic run_command(input int gap, input logic spi, input logic [5:0] idx,
                               input logic [31:0] arg, input logic corrupt,
                               input logic expect_resp, input logic [5:0] exp_idx,
                               input logic [31:0] exp_data, input logic exp_illegal);
        logic        got_resp;
        logic        illegal;
        logic [47:0] rsp;
        logic [6:0]  exp_crc;
        logic        exp_idle;
        int          err_before;
        err_before = errors;
        repeat (gap) @(negedge i_clk);
        i_spi_mode = spi;
        send_frame(idx, arg, corrupt);
        receive_frame(got_resp, illegal, rsp);
        if (expect_resp && !got_resp) begin
            report_failure($sformatf("no response to CMD%0d within %0d cycles",
                                     idx, RESP_TIMEOUT));
        end else if (!expect_resp && got_resp) begin
            report_failure($sformatf("CMD%0d was answered but should stay silent", idx));
        end else if (got_resp) begin
            // R3 carries all ones in place of the CRC
            if (idx == ACMD_OP_COND) begin
                exp_crc = 7'h7f;
            end else begin
                exp_crc = frame_crc7({2'b00, exp_idx, exp_data});
            end
            compare_value("transmission bit", rsp[46], 1'b0);
            compare_value("response index", rsp[45:40], exp_idx);
            compare_value("response payload", rsp[39:8], exp_data);
            compare_value("response CRC7", rsp[7:1], exp_crc);
            compare_value("end bit", rsp[0], 1'b1);
            compare_value("illegal flag", illegal, exp_illegal);
            if (idx == CMD_GO_IDLE || idx == ACMD_OP_COND) begin
                // ACMD41 leaves IDLE on a window match once power-up is done
                exp_idle = (idx == CMD_GO_IDLE) ||
                           ((exp_data[23:0] != 0) && !(exp_data[31] && !spi));
                compare_value("idle state", o_idle_state, exp_idle);
            end
        end
        n_cmds++;
        if (errors != err_before) begin
            n_failed++;
        end
        $display("cmd %0d CMD%0d arg %h at cycle %0d: %s", n_cmds, idx, arg, cycle,
                 (errors == err_before) ? "ok" : "mismatch");
    endtask

    initial begin
        int          fd;
        int          n;
        int          gap;
        int          spi;
        int          corrupt;
        int          expect_resp;
        int          exp_illegal;
        logic [31:0] cmd_h;
        logic [31:0] arg;
        logic [31:0] ridx;
        logic [31:0] rdata;
        string       line;
        i_clk = 1'b0;
        i_nrst = 1'b0;
        i_spi_mode = 1'b0;
        i_cmd = 1'b1;
        errors = 0;
        checks = 0;
        n_cmds = 0;
        n_failed = 0;
        repeat (10) @(posedge i_clk);
        @(negedge i_clk);
        i_nrst = 1'b1;
        check_reset_outputs();
        fd = $fopen("sdcard_golden.txt", "r");
        if (fd == 0) begin
            report_failure("could not open sdcard_golden.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) != 0 && line.len() > 0 && line[0] != "#") begin
                    n = $sscanf(line, "%d %d %h %h %d %d %h %h %d", gap, spi, cmd_h, arg,
                                corrupt, expect_resp, ridx, rdata, exp_illegal);
                    if (n == 9) begin
                        run_command(gap, spi[0], cmd_h[5:0], arg, corrupt[0],
                                    expect_resp[0], ridx[5:0], rdata, exp_illegal[0]);
                    end else if (n > 0) begin
                        report_failure("malformed line in golden file");
                    end
                end
            end
            $fclose(fd);
        end
        if (n_cmds == 0) begin
            report_failure("golden file held no commands");
        end
        errors += DUT.u_asserts.assert_errs;
        $display("%0d commands, %0d with mismatches, %0d checks, %0d assertion errors, %0d errors",
                 n_cmds, n_failed, checks, DUT.u_asserts.assert_errs, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
sdcard_pkg.sv
sdcard_cmd_rx.sv
sdcard_ctrl.sv
sdcard_resp_tx.sv
sdcard_model.sv
sdcard_model_asserts.sv
tb_sdcard_model.sv

//--- sdcard_golden.txt
# gap spi cmd arg corrupt expect resp_idx resp_data illegal
# gap/spi/corrupt/expect/illegal decimal, cmd/arg/resp_idx/resp_data hex
2   0 29 00ff8000 0 1 3f 00ff8000 0
4   0 02 00000000 0 1 02 ffffffff 1
4   0 3a 00000000 0 1 3a ffffffff 1
4   1 3a 00000000 0 1 3a 40ff8000 0
4   0 00 00000000 0 1 00 00000000 0
4   0 08 000001aa 1 0 00 00000000 0
4   0 08 000001aa 0 1 08 000001aa 0
4   0 37 00000000 0 1 37 00000000 0
100 0 29 40ff8000 0 1 3f c0ff8000 0
4   0 0b 00000000 0 1 0b 00000000 0
4   0 14 00000000 0 1 14 ffffffff 1
4   0 02 00000000 0 1 02 5a3c9e01 0
4   0 03 00000000 0 1 03 12340000 0
4   0 00 00000000 0 1 00 00000000 0
4   0 37 00000000 0 1 37 00000000 0
4   0 29 40000000 0 1 3f c0000000 0
4   0 00 00000000 0 0 00 00000000 0
4   0 08 000001aa 0 0 00 00000000 0
